// ==== axi4_read_nd_defines.svh ====
`ifndef AXI4_READ_ND_DEFINES_SVH
`define AXI4_READ_ND_DEFINES_SVH

// ----------------------------------------------------------------------
// AXI4 master side
// ----------------------------------------------------------------------

`define AXI4_ADDR_WIDTH     32
`define AXI4_DATA_WIDTH     32
`define AXI4_LEN_WIDTH      8
`define AXI4_ID_WIDTH       6

// 4 bytes per beat, INCR bursts, bufferable
`define AXI4_ARSIZE         3'd2
`define AXI4_ARBURST        2'b01
`define AXI4_ARCACHE        4'b0001

// ----------------------------------------------------------------------
// frame command fields
// ----------------------------------------------------------------------

`define LINE_LEN_WIDTH      12
`define LINE_CNT_WIDTH      12
`define STEP_WIDTH          32
`define DIM                 2

// flag FIFOs hold 16 records
`define FIFO_DEPTH_LOG      4

`endif

// ==== axi4_read_nd_pkg.sv ====
package axi4_read_nd_pkg;

    `include "axi4_read_nd_defines.svh"

    typedef logic [`AXI4_ADDR_WIDTH-1:0] addr_t;
    typedef logic [`AXI4_DATA_WIDTH-1:0] data_t;
    typedef logic [`LINE_LEN_WIDTH-1:0]  line_len_t;
    typedef logic [`LINE_CNT_WIDTH-1:0]  line_cnt_t;
    typedef logic [`STEP_WIDTH-1:0]      step_t;
    typedef logic [`AXI4_LEN_WIDTH-1:0]  axlen_t;

    // bit 0 line level, bit 1 frame level
    typedef logic [`DIM-1:0] dim_flags_t;

    // per-line record for the read framer
    typedef struct packed {
        dim_flags_t first;
        dim_flags_t last;
        line_len_t  len;
    } line_info_t;

    // per-line record for the completion tracker
    typedef struct packed {
        dim_flags_t first;
        dim_flags_t last;
    } ack_info_t;

endpackage

// ==== address_generator_2d.sv ====
`timescale 1ns/100ps

module address_generator_2d
    import axi4_read_nd_pkg::*;
    (
        input  logic       aclk,
        input  logic       reset,

        input  addr_t      s_araddr,
        input  step_t      s_arstep,
        input  line_len_t  s_arlen,
        input  line_cnt_t  s_arlines,
        input  logic       s_arvalid,
        output logic       s_arready,

        output addr_t      m_addr,
        output line_len_t  m_len,
        output dim_flags_t m_first,
        output dim_flags_t m_last,
        output logic       m_valid,
        input  logic       m_ready
    );

    step_t     step_r;
    line_cnt_t lines_r;
    line_cnt_t line_idx;
    logic      last_line;

    // m_valid stays up for the whole frame, one line per accepted cycle
    assign s_arready = !m_valid;
    assign last_line = (line_idx == lines_r);

    always_ff @(posedge aclk) begin
        if (reset) begin
            m_valid <= 1'b0;
        end else if (s_arvalid && s_arready) begin
            m_valid <= 1'b1;
        end else if (m_valid && m_ready && last_line) begin
            m_valid <= 1'b0;
        end
    end

    always_ff @(posedge aclk) begin
        if (s_arvalid && s_arready) begin
            step_r   <= s_arstep;
            lines_r  <= s_arlines;
            line_idx <= '0;
            m_addr   <= s_araddr;
            m_len    <= s_arlen;
            m_first  <= 2'b11;
            m_last   <= {s_arlines == '0, 1'b1};
        end else if (m_valid && m_ready && !last_line) begin
            // next line of the frame
            line_idx <= line_idx + 1'b1;
            m_addr   <= m_addr + step_r;
            m_first  <= 2'b01;
            m_last   <= {line_idx + 1'b1 == lines_r, 1'b1};
        end
    end

endmodule

// ==== command_broadcast.sv ====
`timescale 1ns/100ps

module command_broadcast
    (
        input  logic       aclk,
        input  logic       reset,

        input  logic       s_valid,
        output logic       s_ready,

        output logic [2:0] m_valid,
        input  logic [2:0] m_ready
    );

    logic [2:0] taken;

    // each consumer sees the command until it has taken it
    assign m_valid = {3{s_valid}} & ~taken;

    // done once every consumer has either taken it earlier or takes it now
    assign s_ready = &(taken | m_ready);

    always_ff @(posedge aclk) begin
        if (reset) begin
            taken <= '0;
        end else if (s_valid && s_ready) begin
            taken <= '0;
        end else begin
            taken <= taken | (m_valid & m_ready);
        end
    end

endmodule

// ==== burst_issuer.sv ====
`timescale 1ns/100ps

`include "axi4_read_nd_defines.svh"

module burst_issuer
    import axi4_read_nd_pkg::*;
    (
        input  logic                      aclk,
        input  logic                      reset,

        input  addr_t                     s_addr,
        input  line_len_t                 s_len,
        input  logic                      s_valid,
        output logic                      s_ready,

        input  axlen_t                    arlen_max,

        output logic [`AXI4_ID_WIDTH-1:0] m_axi4_arid,
        output addr_t                     m_axi4_araddr,
        output axlen_t                    m_axi4_arlen,
        output logic [2:0]                m_axi4_arsize,
        output logic [1:0]                m_axi4_arburst,
        output logic [3:0]                m_axi4_arcache,
        output logic                      m_axi4_arvalid,
        input  logic                      m_axi4_arready
    );

    localparam int REM_W = `LINE_LEN_WIDTH + 1;

    logic             busy;
    logic [REM_W-1:0] rem;
    logic [REM_W-1:0] cur_beats;
    logic [REM_W-1:0] next_rem;

    // length field of the next burst, capped at arlen_max
    function automatic axlen_t burst_len(input logic [REM_W-1:0] beats,
                                         input axlen_t max_len);
        if (beats > max_len + 1'b1) begin
            return max_len;
        end
        return axlen_t'(beats - 1'b1);
    endfunction

    assign m_axi4_arid    = '0;
    assign m_axi4_arsize  = `AXI4_ARSIZE;
    assign m_axi4_arburst = `AXI4_ARBURST;
    assign m_axi4_arcache = `AXI4_ARCACHE;

    assign s_ready   = !busy;
    assign cur_beats = REM_W'(m_axi4_arlen) + 1'b1;
    assign next_rem  = rem - cur_beats;

    // ------------------------------------------------------------------
    // control
    // ------------------------------------------------------------------

    always_ff @(posedge aclk) begin
        if (reset) begin
            busy           <= 1'b0;
            m_axi4_arvalid <= 1'b0;
        end else if (s_valid && s_ready) begin
            busy           <= 1'b1;
            m_axi4_arvalid <= 1'b1;
        end else if (m_axi4_arvalid && m_axi4_arready && next_rem == '0) begin
            busy           <= 1'b0;
            m_axi4_arvalid <= 1'b0;
        end
    end

    // ------------------------------------------------------------------
    // burst address and length
    // ------------------------------------------------------------------

    always_ff @(posedge aclk) begin
        if (s_valid && s_ready) begin
            rem           <= REM_W'(s_len) + 1'b1;
            m_axi4_araddr <= s_addr;
            m_axi4_arlen  <= burst_len(REM_W'(s_len) + 1'b1, arlen_max);
        end else if (m_axi4_arvalid && m_axi4_arready) begin
            rem           <= next_rem;
            m_axi4_araddr <= m_axi4_araddr + (addr_t'(cur_beats) << `AXI4_ARSIZE);
            m_axi4_arlen  <= burst_len(next_rem, arlen_max);
        end
    end

    // request held stable until the slave takes it
    a_ar_hold : assert property (
        @(posedge aclk) disable iff (reset)
        m_axi4_arvalid && !m_axi4_arready |=>
            m_axi4_arvalid && $stable(m_axi4_araddr) && $stable(m_axi4_arlen)
    );

    a_arlen_max : assert property (
        @(posedge aclk) disable iff (reset)
        m_axi4_arvalid |-> m_axi4_arlen <= arlen_max
    );

endmodule

// ==== flag_fifo.sv ====
`timescale 1ns/100ps

`include "axi4_read_nd_defines.svh"

module flag_fifo
    import axi4_read_nd_pkg::*;
    #(
        parameter type T = line_info_t
    )
    (
        input  logic aclk,
        input  logic reset,

        input  T     s_data,
        input  logic s_valid,
        output logic s_ready,

        output T     m_data,
        output logic m_valid,
        input  logic m_ready
    );

    localparam int LOG   = `FIFO_DEPTH_LOG;
    localparam int DEPTH = 2 ** LOG;

    T           mem [DEPTH];
    logic [LOG:0] wr_ptr;
    logic [LOG:0] rd_ptr;
    logic         full;
    logic         empty;

    assign empty = (wr_ptr == rd_ptr);
    assign full  = (wr_ptr[LOG] != rd_ptr[LOG]) && (wr_ptr[LOG-1:0] == rd_ptr[LOG-1:0]);

    assign s_ready = !full;
    assign m_valid = !empty;

    // first-word fall-through read
    assign m_data = mem[rd_ptr[LOG-1:0]];

    always_ff @(posedge aclk) begin
        if (s_valid && s_ready) begin
            mem[wr_ptr[LOG-1:0]] <= s_data;
        end
    end

    always_ff @(posedge aclk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (s_valid && s_ready) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (m_valid && m_ready) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    // a write while full would land on the unread head record
    a_no_overflow : assert property (
        @(posedge aclk) disable iff (reset)
        full && !m_ready |=> $stable(m_data)
    );

endmodule

// ==== read_framer.sv ====
`timescale 1ns/100ps

module read_framer
    import axi4_read_nd_pkg::*;
    (
        input  logic       aclk,
        input  logic       reset,

        input  line_len_t  s_len,
        input  dim_flags_t s_first,
        input  dim_flags_t s_last,
        input  logic       s_valid,
        output logic       s_ready,

        input  data_t      m_axi4_rdata,
        input  logic       m_axi4_rlast,
        input  logic       m_axi4_rvalid,
        output logic       m_axi4_rready,

        output data_t      s_rdata,
        output dim_flags_t s_rfirst,
        output dim_flags_t s_rlast,
        output logic       s_rvalid,
        input  logic       s_rready,

        output logic       line_done
    );

    line_info_t wr_info;
    line_info_t info;
    logic       info_valid;
    line_len_t  beat_cnt;
    logic       first_beat;
    logic       last_beat;
    logic       beat;

    assign wr_info = '{first: s_first, last: s_last, len: s_len};

    flag_fifo #(
        .T       (line_info_t)
    ) i_flag_fifo (
        .aclk    (aclk),
        .reset   (reset),
        .s_data  (wr_info),
        .s_valid (s_valid),
        .s_ready (s_ready),
        .m_data  (info),
        .m_valid (info_valid),
        .m_ready (line_done)
    );

    // beats pass only while the current line is known
    assign m_axi4_rready = info_valid && s_rready;
    assign s_rvalid      = info_valid && m_axi4_rvalid;
    assign s_rdata       = m_axi4_rdata;

    assign first_beat = (beat_cnt == '0);
    assign last_beat  = (beat_cnt == info.len);
    assign s_rfirst   = first_beat ? info.first : '0;
    assign s_rlast    = last_beat ? info.last : '0;

    assign beat      = s_rvalid && s_rready;
    assign line_done = beat && last_beat;

    always_ff @(posedge aclk) begin
        if (reset) begin
            beat_cnt <= '0;
        end else if (line_done) begin
            beat_cnt <= '0;
        end else if (beat) begin
            beat_cnt <= beat_cnt + 1'b1;
        end
    end

    // the line end must coincide with the end of a burst from the slave
    a_line_end_rlast : assert property (
        @(posedge aclk) disable iff (reset)
        line_done |-> m_axi4_rlast
    );

endmodule

// ==== completion_tracker.sv ====
`timescale 1ns/100ps

`include "axi4_read_nd_defines.svh"

module completion_tracker
    import axi4_read_nd_pkg::*;
    (
        input  logic       aclk,
        input  logic       reset,

        input  dim_flags_t s_first,
        input  dim_flags_t s_last,
        input  logic       s_valid,
        output logic       s_ready,

        input  logic       line_done,

        output dim_flags_t s_cfirst,
        output dim_flags_t s_clast,
        output logic       s_cvalid,
        input  logic       s_cready
    );

    ack_info_t                  wr_info;
    ack_info_t                  info;
    logic                       info_valid;
    logic                       pop;
    logic [`FIFO_DEPTH_LOG:0]   done_cnt;

    assign wr_info = '{first: s_first, last: s_last};

    flag_fifo #(
        .T       (ack_info_t)
    ) i_flag_fifo (
        .aclk    (aclk),
        .reset   (reset),
        .s_data  (wr_info),
        .s_valid (s_valid),
        .s_ready (s_ready),
        .m_data  (info),
        .m_valid (info_valid),
        .m_ready (pop)
    );

    assign s_cvalid = (done_cnt != '0);
    assign s_cfirst = info.first;
    assign s_clast  = info.last;
    assign pop      = s_cvalid && s_cready;

    // finished lines not yet reported
    always_ff @(posedge aclk) begin
        if (reset) begin
            done_cnt <= '0;
        end else if (line_done && !pop) begin
            done_cnt <= done_cnt + 1'b1;
        end else if (pop && !line_done) begin
            done_cnt <= done_cnt - 1'b1;
        end
    end

    // a wrap below zero shows as more lines than queued or pending records
    a_no_underflow : assert property (
        @(posedge aclk) disable iff (reset)
        done_cnt <= (2 ** `FIFO_DEPTH_LOG) + 1
    );

    // a finished line always still has its record queued
    a_record_present : assert property (
        @(posedge aclk) disable iff (reset)
        s_cvalid |-> info_valid
    );

endmodule

// ==== axi4_read_nd.sv ====
`timescale 1ns/100ps

`include "axi4_read_nd_defines.svh"

module axi4_read_nd
    import axi4_read_nd_pkg::*;
    (
        input  logic                      aclk,
        input  logic                      reset,

        input  axlen_t                    arlen_max,

        input  addr_t                     s_araddr,
        input  step_t                     s_arstep,
        input  line_len_t                 s_arlen,
        input  line_cnt_t                 s_arlines,
        input  logic                      s_arvalid,
        output logic                      s_arready,

        output data_t                     s_rdata,
        output dim_flags_t                s_rfirst,
        output dim_flags_t                s_rlast,
        output logic                      s_rvalid,
        input  logic                      s_rready,

        output dim_flags_t                s_cfirst,
        output dim_flags_t                s_clast,
        output logic                      s_cvalid,
        input  logic                      s_cready,

        output logic [`AXI4_ID_WIDTH-1:0] m_axi4_arid,
        output addr_t                     m_axi4_araddr,
        output axlen_t                    m_axi4_arlen,
        output logic [2:0]                m_axi4_arsize,
        output logic [1:0]                m_axi4_arburst,
        output logic [3:0]                m_axi4_arcache,
        output logic                      m_axi4_arvalid,
        input  logic                      m_axi4_arready,
        input  logic [`AXI4_ID_WIDTH-1:0] m_axi4_rid,
        input  data_t                     m_axi4_rdata,
        input  logic [1:0]                m_axi4_rresp,
        input  logic                      m_axi4_rlast,
        input  logic                      m_axi4_rvalid,
        output logic                      m_axi4_rready
    );

    // ------------------------------------------------------------------
    // frame to line commands
    // ------------------------------------------------------------------

    addr_t      line_addr;
    line_len_t  line_len;
    dim_flags_t line_first;
    dim_flags_t line_last;
    logic       line_valid;
    logic       line_ready;
    logic [2:0] cmd_valid;
    logic [2:0] cmd_ready;
    logic       line_done;

    address_generator_2d i_address_generator_2d (
        .aclk      (aclk),
        .reset     (reset),
        .s_araddr  (s_araddr),
        .s_arstep  (s_arstep),
        .s_arlen   (s_arlen),
        .s_arlines (s_arlines),
        .s_arvalid (s_arvalid),
        .s_arready (s_arready),
        .m_addr    (line_addr),
        .m_len     (line_len),
        .m_first   (line_first),
        .m_last    (line_last),
        .m_valid   (line_valid),
        .m_ready   (line_ready)
    );

    // 0 issuer, 1 framer, 2 completion tracker
    command_broadcast i_command_broadcast (
        .aclk    (aclk),
        .reset   (reset),
        .s_valid (line_valid),
        .s_ready (line_ready),
        .m_valid (cmd_valid),
        .m_ready (cmd_ready)
    );

    // ------------------------------------------------------------------
    // AR channel, R channel, completions
    // ------------------------------------------------------------------

    burst_issuer i_burst_issuer (
        .aclk           (aclk),
        .reset          (reset),
        .s_addr         (line_addr),
        .s_len          (line_len),
        .s_valid        (cmd_valid[0]),
        .s_ready        (cmd_ready[0]),
        .arlen_max      (arlen_max),
        .m_axi4_arid    (m_axi4_arid),
        .m_axi4_araddr  (m_axi4_araddr),
        .m_axi4_arlen   (m_axi4_arlen),
        .m_axi4_arsize  (m_axi4_arsize),
        .m_axi4_arburst (m_axi4_arburst),
        .m_axi4_arcache (m_axi4_arcache),
        .m_axi4_arvalid (m_axi4_arvalid),
        .m_axi4_arready (m_axi4_arready)
    );

    read_framer i_read_framer (
        .aclk          (aclk),
        .reset         (reset),
        .s_len         (line_len),
        .s_first       (line_first),
        .s_last        (line_last),
        .s_valid       (cmd_valid[1]),
        .s_ready       (cmd_ready[1]),
        .m_axi4_rdata  (m_axi4_rdata),
        .m_axi4_rlast  (m_axi4_rlast),
        .m_axi4_rvalid (m_axi4_rvalid),
        .m_axi4_rready (m_axi4_rready),
        .s_rdata       (s_rdata),
        .s_rfirst      (s_rfirst),
        .s_rlast       (s_rlast),
        .s_rvalid      (s_rvalid),
        .s_rready      (s_rready),
        .line_done     (line_done)
    );

    completion_tracker i_completion_tracker (
        .aclk      (aclk),
        .reset     (reset),
        .s_first   (line_first),
        .s_last    (line_last),
        .s_valid   (cmd_valid[2]),
        .s_ready   (cmd_ready[2]),
        .line_done (line_done),
        .s_cfirst  (s_cfirst),
        .s_clast   (s_clast),
        .s_cvalid  (s_cvalid),
        .s_cready  (s_cready)
    );

endmodule

// ==== axi4_slave_model.sv ====
`timescale 1ns/100ps

module axi4_slave_model
    import axi4_read_nd_pkg::*;
    (
        input  logic   aclk,
        input  logic   reset,

        input  addr_t  araddr,
        input  axlen_t arlen,
        input  logic   arvalid,
        output logic   arready,

        output data_t  rdata,
        output logic   rlast,
        output logic   rvalid,
        input  logic   rready
    );

    addr_t  pend_addr [$];
    axlen_t pend_len [$];
    addr_t  cur_addr;
    axlen_t cur_len;
    axlen_t beat_idx;
    logic   active;

    // every burst seen on AR, in arrival order
    addr_t  rec_addr [256];
    axlen_t rec_len [256];
    int     rec_count;

    assign arready = 1'b1;
    assign rvalid  = active;
    assign rdata   = cur_addr + (addr_t'(beat_idx) << 2);
    assign rlast   = active && (beat_idx == cur_len);

    always @(posedge aclk) begin
        if (reset) begin
            active    <= 1'b0;
            beat_idx  <= '0;
            rec_count <= 0;
        end else begin
            if (active && rready) begin
                if (beat_idx == cur_len) begin
                    active   <= 1'b0;
                    beat_idx <= '0;
                end else begin
                    beat_idx <= beat_idx + 1'b1;
                end
            end else if (!active && pend_addr.size() > 0) begin
                // next queued burst
                active   <= 1'b1;
                cur_addr <= pend_addr.pop_front();
                cur_len  <= pend_len.pop_front();
            end
            if (arvalid && arready) begin
                pend_addr.push_back(araddr);
                pend_len.push_back(arlen);
                rec_addr[rec_count] <= araddr;
                rec_len[rec_count]  <= arlen;
                rec_count           <= rec_count + 1;
            end
        end
    end

endmodule

// ==== tb_axi4_read_nd.sv ====
`timescale 1ns/100ps

`include "axi4_read_nd_defines.svh"

module tb_axi4_read_nd
    import axi4_read_nd_pkg::*;
    ();

    localparam int CLK_PERIOD = 20;
    // 94 beats in all at eight cycles each plus a wide margin
    localparam int MAX_CYCLES = 20000;

    logic                      aclk;
    logic                      reset;
    axlen_t                    arlen_max;
    addr_t                     s_araddr;
    step_t                     s_arstep;
    line_len_t                 s_arlen;
    line_cnt_t                 s_arlines;
    logic                      s_arvalid;
    logic                      s_arready;
    data_t                     s_rdata;
    dim_flags_t                s_rfirst;
    dim_flags_t                s_rlast;
    logic                      s_rvalid;
    logic                      s_rready;
    dim_flags_t                s_cfirst;
    dim_flags_t                s_clast;
    logic                      s_cvalid;
    logic                      s_cready;
    logic [`AXI4_ID_WIDTH-1:0] m_axi4_arid;
    addr_t                     m_axi4_araddr;
    axlen_t                    m_axi4_arlen;
    logic [2:0]                m_axi4_arsize;
    logic [1:0]                m_axi4_arburst;
    logic [3:0]                m_axi4_arcache;
    logic                      m_axi4_arvalid;
    logic                      m_axi4_arready;
    data_t                     m_axi4_rdata;
    logic                      m_axi4_rlast;
    logic                      m_axi4_rvalid;
    logic                      m_axi4_rready;

    int    seed = 84;
    int    errors;
    int    checks;
    int    tests_run;
    int    tests_failed;
    int    test_errors;
    int    cycles;
    string cur_test;

    axi4_read_nd i_axi4_read_nd (
        .aclk           (aclk),
        .reset          (reset),
        .arlen_max      (arlen_max),
        .s_araddr       (s_araddr),
        .s_arstep       (s_arstep),
        .s_arlen        (s_arlen),
        .s_arlines      (s_arlines),
        .s_arvalid      (s_arvalid),
        .s_arready      (s_arready),
        .s_rdata        (s_rdata),
        .s_rfirst       (s_rfirst),
        .s_rlast        (s_rlast),
        .s_rvalid       (s_rvalid),
        .s_rready       (s_rready),
        .s_cfirst       (s_cfirst),
        .s_clast        (s_clast),
        .s_cvalid       (s_cvalid),
        .s_cready       (s_cready),
        .m_axi4_arid    (m_axi4_arid),
        .m_axi4_araddr  (m_axi4_araddr),
        .m_axi4_arlen   (m_axi4_arlen),
        .m_axi4_arsize  (m_axi4_arsize),
        .m_axi4_arburst (m_axi4_arburst),
        .m_axi4_arcache (m_axi4_arcache),
        .m_axi4_arvalid (m_axi4_arvalid),
        .m_axi4_arready (m_axi4_arready),
        .m_axi4_rid     ('0),
        .m_axi4_rdata   (m_axi4_rdata),
        .m_axi4_rresp   (2'b00),
        .m_axi4_rlast   (m_axi4_rlast),
        .m_axi4_rvalid  (m_axi4_rvalid),
        .m_axi4_rready  (m_axi4_rready)
    );

    axi4_slave_model i_axi4_slave_model (
        .aclk    (aclk),
        .reset   (reset),
        .araddr  (m_axi4_araddr),
        .arlen   (m_axi4_arlen),
        .arvalid (m_axi4_arvalid),
        .arready (m_axi4_arready),
        .rdata   (m_axi4_rdata),
        .rlast   (m_axi4_rlast),
        .rvalid  (m_axi4_rvalid),
        .rready  (m_axi4_rready)
    );

    initial begin
        aclk = 1'b0;
        forever #(CLK_PERIOD / 2) aclk = ~aclk;
    end

    // ------------------------------------------------------------------
    // checking and bookkeeping
    // ------------------------------------------------------------------

    task automatic compare(input string what, input logic [31:0] expected,
                           input logic [31:0] actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("Mismatch %s %s: expected %0h, actual %0h",
                     cur_test, what, expected, actual);
        end
    endtask

    task automatic start_test(input string name);
        cur_test    = name;
        test_errors = errors;
    endtask

    task automatic end_test();
        tests_run++;
        if (errors == test_errors) begin
            $display("%s: ok", cur_test);
        end else begin
            tests_failed++;
            $display("%s: FAILED with %0d errors", cur_test, errors - test_errors);
        end
    endtask

    // fixed AR attributes on every accepted request
    task automatic check_ar_fields();
        compare("arid", 0, m_axi4_arid);
        compare("arsize", 2, m_axi4_arsize);
        compare("arburst", 1, m_axi4_arburst);
        compare("arcache", 1, m_axi4_arcache);
    endtask

    // ------------------------------------------------------------------
    // frame driver, beat collector, burst checker
    // ------------------------------------------------------------------

    task automatic read_frame(input addr_t base, input step_t step, input int len,
                              input int lines, input bit random_ready);
        int         beats;
        int         line_i;
        int         beat_j;
        logic [1:0] exp_first;
        logic [1:0] exp_last;
        beats = 0;
        while (beats < len * lines) begin
            @(posedge aclk);
            if (m_axi4_arvalid && m_axi4_arready) begin
                check_ar_fields();
            end
            if (s_rvalid && s_rready) begin
                line_i    = beats / len;
                beat_j    = beats % len;
                exp_first = (beat_j == 0) ? ((line_i == 0) ? 2'd3 : 2'd1) : 2'd0;
                exp_last  = (beat_j == len - 1) ? ((line_i == lines - 1) ? 2'd3 : 2'd1) : 2'd0;
                compare("rdata", base + line_i * step + 4 * beat_j, s_rdata);
                compare("rfirst", exp_first, s_rfirst);
                compare("rlast", exp_last, s_rlast);
                beats++;
            end
            #2;
            s_rready = random_ready ? (($random(seed) & 1) == 1) : 1'b1;
        end
        s_rready = 1'b1;
    endtask

    task automatic check_bursts(input int first_rec, input addr_t base, input step_t step,
                                input int len, input int lines, input int max_beats);
        int    rec;
        int    remain;
        int    blen;
        int    i;
        addr_t addr;
        rec = first_rec;
        for (i = 0; i < lines; i++) begin
            addr   = base + i * step;
            remain = len;
            while (remain > 0) begin
                blen = (remain > max_beats) ? max_beats : remain;
                compare("araddr", addr, i_axi4_slave_model.rec_addr[rec]);
                compare("burst beats", blen, i_axi4_slave_model.rec_len[rec] + 1);
                addr   = addr + 4 * blen;
                remain = remain - blen;
                rec++;
            end
        end
        compare("burst count", rec - first_rec, i_axi4_slave_model.rec_count - first_rec);
    endtask

    // called and returns 2 ns after a rising edge
    task automatic run_frame(input addr_t base, input step_t step, input int len,
                             input int lines, input int max_beats, input bit random_ready);
        int first_rec;
        first_rec = i_axi4_slave_model.rec_count;
        arlen_max = axlen_t'(max_beats - 1);
        s_araddr  = base;
        s_arstep  = step;
        s_arlen   = line_len_t'(len - 1);
        s_arlines = line_cnt_t'(lines - 1);
        s_arvalid = 1'b1;
        do begin
            @(posedge aclk);
        end while (!s_arready);
        #2;
        s_arvalid = 1'b0;
        // frame taken and being expanded
        compare("arready while busy", 0, s_arready);
        read_frame(base, step, len, lines, random_ready);
        check_bursts(first_rec, base, step, len, lines, max_beats);
    endtask

    // ------------------------------------------------------------------
    // directed tests
    // ------------------------------------------------------------------

    task automatic test_single_line();
        start_test("single_line");
        run_frame(32'h0000_1000, 32'h100, 8, 1, 16, 1'b0);
        end_test();
    endtask

    task automatic test_frame_2d();
        start_test("frame_2d");
        run_frame(32'h0000_2000, 32'd256, 6, 4, 16, 1'b0);
        end_test();
    endtask

    task automatic test_burst_split();
        start_test("burst_split");
        run_frame(32'h0000_3000, 32'h100, 20, 1, 8, 1'b0);
        end_test();
    endtask

    task automatic test_read_backpressure();
        start_test("read_backpressure");
        run_frame(32'h0000_5000, 32'h40, 10, 3, 16, 1'b1);
        end_test();
    endtask

    task automatic test_completions();
        int got;
        int extra;
        start_test("completions");
        // let completions of the previous frame drain first
        while (s_cvalid) begin
            @(posedge aclk);
            #2;
        end
        s_cready = 1'b0;
        run_frame(32'h0000_4000, 32'h80, 4, 3, 16, 1'b0);
        // all three lines finished and none taken yet
        compare("cvalid held", 1, s_cvalid);
        s_cready = 1'b1;
        got = 0;
        while (got < 3) begin
            @(posedge aclk);
            if (s_cvalid && s_cready) begin
                compare("cfirst", (got == 0) ? 3 : 1, s_cfirst);
                compare("clast", (got == 2) ? 3 : 1, s_clast);
                got++;
            end
        end
        extra = 0;
        repeat (10) begin
            @(posedge aclk);
            if (s_cvalid) begin
                extra++;
            end
        end
        compare("extra completions", 0, extra);
        #2;
        end_test();
    endtask

    // ------------------------------------------------------------------
    // main sequence and timeout
    // ------------------------------------------------------------------

    initial begin
        reset        = 1'b1;
        arlen_max    = 8'd15;
        s_araddr     = '0;
        s_arstep     = '0;
        s_arlen      = '0;
        s_arlines    = '0;
        s_arvalid    = 1'b0;
        s_rready     = 1'b1;
        s_cready     = 1'b1;
        errors       = 0;
        checks       = 0;
        tests_run    = 0;
        tests_failed = 0;
        repeat (8) @(posedge aclk);
        #2;
        reset = 1'b0;

        test_single_line();
        test_frame_2d();
        test_burst_split();
        test_read_backpressure();
        test_completions();

        $display("tests run %0d, passed %0d, failed %0d; checks %0d, errors %0d",
                 tests_run, tests_run - tests_failed, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    initial begin
        cycles = 0;
        while (cycles < MAX_CYCLES) begin
            @(posedge aclk);
            cycles++;
        end
        $display("timeout: run did not finish within %0d clock cycles", MAX_CYCLES);
        $display("Test failed");
        $finish;
    end

endmodule

// ==== sources.f ====
+incdir+.
axi4_read_nd_pkg.sv
address_generator_2d.sv
command_broadcast.sv
burst_issuer.sv
flag_fifo.sv
read_framer.sv
completion_tracker.sv
axi4_read_nd.sv
axi4_slave_model.sv
tb_axi4_read_nd.sv
